// File: hdl/arith_unit.sv
//======================================================================
// fixflo arithmetic stage
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module arith_unit (
  input  logic                          clk,
  input  logic                          reset,
  op_if.executor                        op,
  output logic                          res_valid,
  output logic [fixflo_pkg::DATA_W-1:0] res_data,
  output fixflo_pkg::flags_t            res_flags
);

  logic [fixflo_pkg::DATA_W:0]     add_full;   // carry in msb
  logic [2*fixflo_pkg::DATA_W-1:0] mul_full;
  logic [fixflo_pkg::DATA_W-1:0]   flt_prod;
  fixflo_pkg::flags_t              flt_flags;
  logic [fixflo_pkg::DATA_W-1:0]   nxt_data;
  fixflo_pkg::flags_t              nxt_flags;

  float_mul u_float_mul (
    .a       (op.a),
    .b       (op.b),
    .product (flt_prod),
    .flags   (flt_flags)
  );

  assign add_full = {1'b0, op.a} + {1'b0, op.b};
  assign mul_full = op.a * op.b;

  always_comb
  begin
    nxt_flags = '0;
    case (op.opcode)
      fixflo_pkg::OP_FIX_ADD:
      begin
        nxt_data           = add_full[fixflo_pkg::DATA_W-1:0];
        nxt_flags.overflow = add_full[fixflo_pkg::DATA_W];
        nxt_flags.zero     = (nxt_data == '0);
      end
      fixflo_pkg::OP_FIX_MUL:
      begin
        // middle 16 bits keep the 8.8 point
        nxt_data            = mul_full[fixflo_pkg::FRAC_W +: fixflo_pkg::DATA_W];
        nxt_flags.overflow  = |mul_full[2*fixflo_pkg::DATA_W-1 :
                                        fixflo_pkg::DATA_W+fixflo_pkg::FRAC_W];
        nxt_flags.prec_lost = |mul_full[fixflo_pkg::FRAC_W-1:0];
        nxt_flags.zero      = (nxt_data == '0);
      end
      fixflo_pkg::OP_FLT_MUL:
      begin
        nxt_data  = flt_prod;
        nxt_flags = flt_flags;
      end
      default: nxt_data = '0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      res_valid <= 1'b0;
      res_data  <= '0;
      res_flags <= '0;
    end
    else
    begin
      res_valid <= op.start;
      if (op.start)
      begin
        res_data  <= nxt_data;
        res_flags <= nxt_flags;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/fixflo_pkg.sv
//======================================================================
// fixflo shared definitions
//======================================================================
`default_nettype none

package fixflo_pkg;

  // operand and fixed-point format
  localparam int DATA_W = 16;
  localparam int FRAC_W = 8;   // 8.8 unsigned

  // binary16 fields
  localparam int MAN_W    = 10;
  localparam int EXP_W    = 5;
  localparam int EXP_BIAS = 15;
  localparam int EXP_MAX  = 31;
  localparam logic [DATA_W-1:0] QNAN = 16'h7E00;

  // register map, word addresses
  localparam int ADR_W = 3;
  localparam logic [ADR_W-1:0] REG_A      = 3'd0;
  localparam logic [ADR_W-1:0] REG_B      = 3'd1;
  localparam logic [ADR_W-1:0] REG_CTRL   = 3'd2; // write only, launches
  localparam logic [ADR_W-1:0] REG_RESULT = 3'd3;
  localparam logic [ADR_W-1:0] REG_STATUS = 3'd4;

  // status word layout
  localparam int STAT_FLAGS_LSB = 0;
  localparam int STAT_DONE      = 8;

  typedef enum logic [1:0] {
    OP_FIX_ADD = 2'd0,
    OP_FIX_MUL = 2'd1,
    OP_FLT_MUL = 2'd2
  } op_e;  // 3 is not a valid opcode

  typedef struct packed {
    logic overflow;
    logic zero;
    logic nan;
    logic prec_lost;
  } flags_t;

endpackage

`default_nettype wire

// File: hdl/fixflo_top.sv
//======================================================================
// fixflo arithmetic peripheral
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module fixflo_top (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  logic [fixflo_pkg::ADR_W-1:0]  wb_adr,
  input  logic [fixflo_pkg::DATA_W-1:0] wb_dat_i,
  output logic [fixflo_pkg::DATA_W-1:0] wb_dat_o,
  output logic                          wb_ack
);

  op_if op_bus ();

  logic                          res_valid;
  logic [fixflo_pkg::DATA_W-1:0] res_data;
  fixflo_pkg::flags_t            res_flags;
  logic [fixflo_pkg::DATA_W-1:0] res_word;
  fixflo_pkg::flags_t            stored_flags;
  logic                          done;
  logic                          rd_result;

  wb_op_regs u_wb_op_regs (
    .clk       (clk),
    .reset     (reset),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack    (wb_ack),
    .op        (op_bus.issuer),
    .res_word  (res_word),
    .res_flags (stored_flags),
    .done      (done),
    .rd_result (rd_result)
  );

  arith_unit u_arith_unit (
    .clk       (clk),
    .reset     (reset),
    .op        (op_bus.executor),
    .res_valid (res_valid),
    .res_data  (res_data),
    .res_flags (res_flags)
  );

  result_regs u_result_regs (
    .clk       (clk),
    .reset     (reset),
    .res_valid (res_valid),
    .res_data  (res_data),
    .res_flags (res_flags),
    .rd_result (rd_result),
    .res_word  (res_word),
    .flags     (stored_flags),
    .done      (done)
  );

endmodule

`default_nettype wire

// File: hdl/float_mul.sv
//======================================================================
// binary16 multiplier, truncating
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module float_mul (
  input  logic [fixflo_pkg::DATA_W-1:0] a,
  input  logic [fixflo_pkg::DATA_W-1:0] b,
  output logic [fixflo_pkg::DATA_W-1:0] product,
  output fixflo_pkg::flags_t            flags
);

  logic                          sa, sb, sr;
  logic [fixflo_pkg::EXP_W-1:0]  ea, eb;
  logic [fixflo_pkg::MAN_W-1:0]  fa, fb;
  logic                          a_zero, b_zero;
  logic                          a_inf, b_inf;
  logic                          a_nan, b_nan;
  logic [2*fixflo_pkg::MAN_W+1:0] sig_prod;  // 11 x 11 bits
  logic                          norm;
  logic [fixflo_pkg::MAN_W-1:0]  mant;
  logic                          lost;
  logic [fixflo_pkg::EXP_W:0]    exp_raw;   // still carries both biases
  logic [fixflo_pkg::EXP_W:0]    exp_unb;

  assign {sa, ea, fa} = a;
  assign {sb, eb, fb} = b;
  assign sr = sa ^ sb;

  // subnormals are taken as zero
  assign a_zero = (ea == '0);
  assign b_zero = (eb == '0);
  assign a_inf  = (ea == fixflo_pkg::EXP_MAX) && (fa == '0);
  assign b_inf  = (eb == fixflo_pkg::EXP_MAX) && (fb == '0);
  assign a_nan  = (ea == fixflo_pkg::EXP_MAX) && (fa != '0);
  assign b_nan  = (eb == fixflo_pkg::EXP_MAX) && (fb != '0);

  assign sig_prod = {1'b1, fa} * {1'b1, fb};
  assign norm     = sig_prod[2*fixflo_pkg::MAN_W+1]; // product in [2,4)

  // one place of normalisation at most
  assign mant = norm ? sig_prod[2*fixflo_pkg::MAN_W -: fixflo_pkg::MAN_W]
                     : sig_prod[2*fixflo_pkg::MAN_W-1 -: fixflo_pkg::MAN_W];
  assign lost = norm ? |sig_prod[fixflo_pkg::MAN_W:0]
                     : |sig_prod[fixflo_pkg::MAN_W-1:0];

  assign exp_raw = {1'b0, ea} + {1'b0, eb} + {{fixflo_pkg::EXP_W{1'b0}}, norm};
  assign exp_unb = exp_raw - (fixflo_pkg::EXP_W+1)'(fixflo_pkg::EXP_BIAS);

  always_comb
  begin
    flags = '0;
    if (a_nan || b_nan || (a_inf && b_zero) || (b_inf && a_zero))
    begin
      product   = fixflo_pkg::QNAN;
      flags.nan = 1'b1;
    end
    else if (a_inf || b_inf)
    begin
      product        = {sr, {fixflo_pkg::EXP_W{1'b1}}, {fixflo_pkg::MAN_W{1'b0}}};
      flags.overflow = 1'b1;
    end
    else if (a_zero || b_zero)
    begin
      product    = {sr, {(fixflo_pkg::DATA_W-1){1'b0}}};
      flags.zero = 1'b1;
    end
    else if (exp_raw >= fixflo_pkg::EXP_MAX + fixflo_pkg::EXP_BIAS)
    begin
      product        = {sr, {fixflo_pkg::EXP_W{1'b1}}, {fixflo_pkg::MAN_W{1'b0}}};
      flags.overflow = 1'b1;
    end
    else if (exp_raw < 1 + fixflo_pkg::EXP_BIAS)
    begin
      // flush, no subnormal results
      product         = {sr, {(fixflo_pkg::DATA_W-1){1'b0}}};
      flags.zero      = 1'b1;
      flags.prec_lost = 1'b1;
    end
    else
    begin
      product         = {sr, exp_unb[fixflo_pkg::EXP_W-1:0], mant};
      flags.prec_lost = lost;
    end
  end

endmodule

`default_nettype wire

// File: hdl/op_if.sv
//======================================================================
// operation request channel
//======================================================================
`timescale 1ns/1ps
`default_nettype none

interface op_if;
  logic                            start;   // one cycle pulse
  fixflo_pkg::op_e                 opcode;
  logic [fixflo_pkg::DATA_W-1:0]   a;
  logic [fixflo_pkg::DATA_W-1:0]   b;

  // bus side
  modport issuer   (output start, opcode, a, b);
  // arithmetic side
  modport executor (input  start, opcode, a, b);
endinterface

`default_nettype wire

// File: hdl/result_regs.sv
//======================================================================
// fixflo result holding registers
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module result_regs (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          res_valid,
  input  logic [fixflo_pkg::DATA_W-1:0] res_data,
  input  fixflo_pkg::flags_t            res_flags,
  input  logic                          rd_result,
  output logic [fixflo_pkg::DATA_W-1:0] res_word,
  output fixflo_pkg::flags_t            flags,
  output logic                          done
);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      res_word <= '0;
      flags    <= '0;
      done     <= 1'b0;
    end
    else
    begin
      if (res_valid)
      begin
        res_word <= res_data;   // newest result overwrites
        flags    <= res_flags;
        done     <= 1'b1;
      end
      else if (rd_result)
        done <= 1'b0;           // new result beats the clear
    end
  end

endmodule

`default_nettype wire

// File: hdl/wb_op_regs.sv
//======================================================================
// fixflo wishbone register slave
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module wb_op_regs (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            wb_cyc,
  input  logic                            wb_stb,
  input  logic                            wb_we,
  input  logic [fixflo_pkg::ADR_W-1:0]    wb_adr,
  input  logic [fixflo_pkg::DATA_W-1:0]   wb_dat_i,
  output logic [fixflo_pkg::DATA_W-1:0]   wb_dat_o,
  output logic                            wb_ack,
  op_if.issuer                            op,
  input  logic [fixflo_pkg::DATA_W-1:0]   res_word,
  input  fixflo_pkg::flags_t              res_flags,
  input  logic                            done,
  output logic                            rd_result
);

  logic                          req;
  logic                          acc;       // request being accepted this edge
  logic [fixflo_pkg::DATA_W-1:0] reg_a;
  logic [fixflo_pkg::DATA_W-1:0] reg_b;
  logic [fixflo_pkg::DATA_W-1:0] status;
  logic [fixflo_pkg::DATA_W-1:0] rd_mux;

  assign req = wb_cyc & wb_stb;
  assign acc = req & ~wb_ack;   // ack only on a fresh request

  // done clears on the same edge that acks the read
  assign rd_result = acc & ~wb_we & (wb_adr == fixflo_pkg::REG_RESULT);

  assign op.a = reg_a;
  assign op.b = reg_b;

  always_comb
  begin
    status = '0;
    status[fixflo_pkg::STAT_FLAGS_LSB +: 4] = res_flags;
    status[fixflo_pkg::STAT_DONE]           = done;
  end

  always_comb
  begin
    case (wb_adr)
      fixflo_pkg::REG_A:      rd_mux = reg_a;
      fixflo_pkg::REG_B:      rd_mux = reg_b;
      fixflo_pkg::REG_RESULT: rd_mux = res_word;
      fixflo_pkg::REG_STATUS: rd_mux = status;
      default:                rd_mux = '0;   // ctrl reads as zero
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wb_ack    <= 1'b0;
      wb_dat_o  <= '0;
      reg_a     <= '0;
      reg_b     <= '0;
      op.start  <= 1'b0;
      op.opcode <= fixflo_pkg::OP_FIX_ADD;
    end
    else
    begin
      wb_ack   <= acc;
      op.start <= 1'b0;
      if (acc && !wb_we)
        wb_dat_o <= rd_mux;
      if (acc && wb_we)
      begin
        case (wb_adr)
          fixflo_pkg::REG_A: reg_a <= wb_dat_i;
          fixflo_pkg::REG_B: reg_b <= wb_dat_i;
          fixflo_pkg::REG_CTRL:
            if (wb_dat_i[1:0] != 2'd3) // opcode 3 is dropped
            begin
              op.start  <= 1'b1;
              op.opcode <= fixflo_pkg::op_e'(wb_dat_i[1:0]);
            end
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, then decide on the log contents
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module fixflo_tb -f tb.f \
  && ./obj_dir/Vfixflo_tb | tee sim.log \
  || { echo "build or run did not complete"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: tb.f
hdl/fixflo_pkg.sv
hdl/op_if.sv
hdl/float_mul.sv
hdl/arith_unit.sv
hdl/result_regs.sv
hdl/wb_op_regs.sv
hdl/fixflo_top.sv
verification/tb_clock.sv
verification/fixflo_monitor.sv
verification/fixflo_checker.sv
verification/fixflo_tb.sv

// File: verification/fixflo_checker.sv
//======================================================================
// wishbone protocol assertions
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module fixflo_checker (
  input logic                         clk,
  input logic                         reset,
  input logic                         wb_cyc,
  input logic                         wb_stb,
  input logic                         wb_we,
  input logic [fixflo_pkg::ADR_W-1:0] wb_adr,
  input logic                         wb_ack,
  input logic                         start
);

  logic req;

  assign req = wb_cyc & wb_stb;

  ack_after_req: assert property (@(posedge clk) disable iff (reset)
    wb_ack |-> $past(req))
    else $error("ack raised without a bus request");

  // single cycle ack
  ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
    wb_ack |=> !wb_ack)
    else $error("ack held high for two cycles");

  start_after_ctrl: assert property (@(posedge clk) disable iff (reset)
    start |-> (wb_ack && $past(req && wb_we && (wb_adr == fixflo_pkg::REG_CTRL))))
    else $error("start pulse without a control register write");

endmodule

`default_nettype wire

// File: verification/fixflo_monitor.sv
//======================================================================
// fixflo bus monitor and result compare
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module fixflo_monitor (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  logic [fixflo_pkg::ADR_W-1:0]  wb_adr,
  input  logic [fixflo_pkg::DATA_W-1:0] wb_dat_i,
  input  logic [fixflo_pkg::DATA_W-1:0] wb_dat_o,
  input  logic                          wb_ack,
  output int                            check_count,
  output int                            error_count
);

  logic [15:0] mdl_a;
  logic [15:0] mdl_b;
  logic [19:0] mdl_res;        // {flags, word} held by the result registers
  logic        mdl_done;
  logic [19:0] pipe_res [2];
  logic [1:0]  pipe_vld;
  logic [19:0] new_res;
  logic        launch;
  logic        clear;
  logic        rd_pend;
  logic [2:0]  rd_adr;
  logic [15:0] rd_exp;

  // returns {overflow, zero, nan, prec_lost, result}
  function automatic logic [19:0] fixflo_ref(input logic [1:0] opc, input logic [15:0] a,
                                             input logic [15:0] b);
    logic [16:0] sum;
    logic [31:0] prod;
    logic [21:0] m;
    logic [15:0] r;
    logic [9:0]  frac;
    logic        lost;
    logic        sign;
    int          e;
    sum  = {1'b0, a} + {1'b0, b};
    prod = {16'd0, a} * {16'd0, b};
    sign = a[15] ^ b[15];
    if (opc == 2'd0)
    begin
      r = sum[15:0];
      return {sum[16], r == 16'd0, 2'b00, r};
    end
    if (opc == 2'd1)
    begin
      r = prod[23:8];   // keeps the 8.8 point
      return {prod[31:24] != 8'd0, r == 16'd0, 1'b0, prod[7:0] != 8'd0, r};
    end
    // exponent 31 is inf or nan, exponent 0 counts as zero
    if ((a[14:10] == 5'd31 && a[9:0] != 10'd0) || (b[14:10] == 5'd31 && b[9:0] != 10'd0) ||
        (a[14:10] == 5'd31 && b[14:10] == 5'd0) || (b[14:10] == 5'd31 && a[14:10] == 5'd0))
      return {4'b0010, 16'h7E00};
    if (a[14:10] == 5'd31 || b[14:10] == 5'd31)
      return {4'b1000, sign, 15'h7C00};
    if (a[14:10] == 5'd0 || b[14:10] == 5'd0)
      return {4'b0100, sign, 15'h0000};
    m = {11'd0, 1'b1, a[9:0]} * {11'd0, 1'b1, b[9:0]};
    e = int'(a[14:10]) + int'(b[14:10]) - 15;
    if (m[21])
    begin
      frac = m[20:11];
      lost = (m[10:0] != 11'd0);
      e    = e + 1;
    end
    else
    begin
      frac = m[19:10];
      lost = (m[9:0] != 10'd0);
    end
    if (e >= 31)
      return {4'b1000, sign, 15'h7C00};
    if (e < 1)
      return {4'b0101, sign, 15'h0000};   // flushed, no subnormals
    return {3'b000, lost, sign, e[4:0], frac};
  endfunction

  initial
  begin
    check_count = 0;
    error_count = 0;
  end

  // samples the values that were stable through the cycle before the edge
  always @(posedge clk)
  begin
    if (reset)
    begin
      mdl_a    = '0;
      mdl_b    = '0;
      mdl_res  = '0;
      mdl_done = 1'b0;
      pipe_vld = '0;
      rd_pend  = 1'b0;
    end
    else
    begin
      if (wb_ack && rd_pend)
      begin
        check_count++;
        if (wb_dat_o !== rd_exp)
        begin
          error_count++;
          $display("FAILED at %0t: register %0d read %h, expected %h",
                   $time, rd_adr, wb_dat_o, rd_exp);
        end
        rd_pend = 1'b0;
      end
      clear  = 1'b0;
      launch = 1'b0;
      if (wb_cyc && wb_stb && !wb_ack)
      begin
        if (!wb_we)
        begin
          rd_pend = 1'b1;
          rd_adr  = wb_adr;
          case (wb_adr)
            fixflo_pkg::REG_A:      rd_exp = mdl_a;
            fixflo_pkg::REG_B:      rd_exp = mdl_b;
            fixflo_pkg::REG_RESULT: rd_exp = mdl_res[15:0];
            fixflo_pkg::REG_STATUS: rd_exp = {7'd0, mdl_done, 4'd0, mdl_res[19:16]};
            default:                rd_exp = '0;
          endcase
          clear = (wb_adr == fixflo_pkg::REG_RESULT);
        end
        else
        begin
          case (wb_adr)
            fixflo_pkg::REG_A: mdl_a = wb_dat_i;
            fixflo_pkg::REG_B: mdl_b = wb_dat_i;
            fixflo_pkg::REG_CTRL:
              if (wb_dat_i[1:0] != 2'd3)
              begin
                launch  = 1'b1;
                new_res = fixflo_ref(wb_dat_i[1:0], mdl_a, mdl_b);
              end
            default: ;
          endcase
        end
      end
      // result lands two edges after the launching ack
      if (pipe_vld[1])
      begin
        mdl_res  = pipe_res[1];
        mdl_done = 1'b1;
      end
      else if (clear)
        mdl_done = 1'b0;
      pipe_vld    = {pipe_vld[0], launch};
      pipe_res[1] = pipe_res[0];
      pipe_res[0] = new_res;
    end
  end

endmodule

`default_nettype wire

// File: verification/fixflo_tb.sv
//======================================================================
// fixflo testbench top
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module fixflo_tb;

  localparam int ACK_LIMIT  = 16;
  localparam int DONE_LIMIT = 8;
  localparam int N_RAND     = 40;

  // float special cases as {a, b}
  localparam logic [31:0] SPECIAL [8] = '{
    32'h7E00_3C00, 32'h3C00_FD00, 32'h7C00_0000, 32'h8000_FC00,
    32'h7C00_4000, 32'hC000_7C00, 32'h0001_3C00, 32'h3C00_8200
  };

  logic                          clk;
  logic                          reset;
  logic                          wb_cyc;
  logic                          wb_stb;
  logic                          wb_we;
  logic [fixflo_pkg::ADR_W-1:0]  wb_adr;
  logic [fixflo_pkg::DATA_W-1:0] wb_dat_i;
  logic [fixflo_pkg::DATA_W-1:0] wb_dat_o;
  logic                          wb_ack;
  int                            check_count;
  int                            error_count;
  int                            timeouts;
  int                            nbits;
  logic [15:0]                   lfsr;
  logic [15:0]                   rd;

  tb_clock u_clock (
    .clk   (clk),
    .reset (reset)
  );

  fixflo_top UUT (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack   (wb_ack)
  );

  fixflo_monitor u_monitor (
    .clk         (clk),
    .reset       (reset),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack      (wb_ack),
    .check_count (check_count),
    .error_count (error_count)
  );

  bind wb_op_regs fixflo_checker u_checker (
    .clk    (clk),
    .reset  (reset),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_we  (wb_we),
    .wb_adr (wb_adr),
    .wb_ack (wb_ack),
    .start  (op.start)
  );

  // galois lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);   // one step per bit
      v    = {v[14:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [15:0] rand_normal();
    logic [15:0] v;
    v = rand_bits(16);
    if (v[14:10] == 5'd0)
      v[14:10] = 5'd1;
    else if (v[14:10] == 5'd31)
      v[14:10] = 5'd30;
    return v;
  endfunction

  task automatic bus_access(input logic we, input logic [2:0] adr, input logic [15:0] wdata,
                            output logic [15:0] rdata);
    int waited;
    waited = 0;
    rdata  = '0;
    @(posedge clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_i = wdata;
    @(posedge clk);
    #1;
    while (!wb_ack && waited < ACK_LIMIT)
    begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (wb_ack)
      rdata = wb_dat_o;
    else
    begin
      timeouts++;
      $display("timeout: no ack from address %0d within %0d cycles", adr, ACK_LIMIT);
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wait_done();
    int polls;
    polls = 0;
    bus_access(1'b0, fixflo_pkg::REG_STATUS, '0, rd);
    while (!rd[8] && polls < DONE_LIMIT)
    begin
      bus_access(1'b0, fixflo_pkg::REG_STATUS, '0, rd);
      polls++;
    end
    if (!rd[8])
    begin
      timeouts++;
      $display("timeout: done bit still low after %0d status reads", polls + 1);
    end
  endtask

  task automatic run_op(input logic [1:0] opc, input logic [15:0] a, input logic [15:0] b);
    bus_access(1'b1, fixflo_pkg::REG_A, a, rd);
    bus_access(1'b1, fixflo_pkg::REG_B, b, rd);
    bus_access(1'b1, fixflo_pkg::REG_CTRL, {14'd0, opc}, rd);
    wait_done();
    bus_access(1'b0, fixflo_pkg::REG_RESULT, '0, rd);
  endtask

  task automatic report(input int n, input string name);
    $display("test %0d %s finished: %0d checks, %0d errors so far",
             n, name, check_count, error_count);
  endtask

  initial
  begin
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_i = '0;
    timeouts = 0;
    lfsr     = 16'd70;
    for (int i = 0; i < 10 && reset !== 1'b0; i++)
      @(posedge clk);
    if (reset !== 1'b0)
    begin
      timeouts++;
      $display("timeout: reset never released");
    end

    if (timeouts == 0)
    begin
      bus_access(1'b1, fixflo_pkg::REG_A, rand_bits(16), rd);
      bus_access(1'b1, fixflo_pkg::REG_B, rand_bits(16), rd);
      bus_access(1'b0, fixflo_pkg::REG_A, '0, rd);
      bus_access(1'b0, fixflo_pkg::REG_B, '0, rd);
      bus_access(1'b1, fixflo_pkg::REG_CTRL, 16'd3, rd);   // dropped opcode
      repeat (4) @(posedge clk);
      bus_access(1'b0, fixflo_pkg::REG_STATUS, '0, rd);
      report(1, "register readback");
    end
    if (timeouts == 0)
    begin
      for (int i = 0; i < N_RAND; i++)
        run_op(2'd0, rand_bits(16), rand_bits(16));
      run_op(2'd0, 16'hC000, 16'h4000);   // wraps to zero with a carry
      report(2, "fixed add");
    end
    if (timeouts == 0)
    begin
      for (int i = 0; i < N_RAND; i++)
      begin
        nbits = (i % 2 == 0) ? 10 : 16;   // small operands keep the product in range
        run_op(2'd1, rand_bits(nbits), rand_bits(nbits));
      end
      run_op(2'd1, 16'h0004, 16'h0010);   // product below one lsb
      report(3, "fixed multiply");
    end
    if (timeouts == 0)
    begin
      for (int i = 0; i < N_RAND; i++)
        run_op(2'd2, rand_normal(), rand_normal());
      report(4, "float multiply");
    end
    if (timeouts == 0)
    begin
      for (int i = 0; i < 8; i++)
        run_op(2'd2, SPECIAL[i][31:16], SPECIAL[i][15:0]);
      report(5, "float specials");
    end
    if (timeouts == 0)
    begin
      // two launches back to back where the second result wins
      bus_access(1'b1, fixflo_pkg::REG_A, 16'h0380, rd);
      bus_access(1'b1, fixflo_pkg::REG_B, 16'h0240, rd);
      bus_access(1'b1, fixflo_pkg::REG_CTRL, 16'd0, rd);
      bus_access(1'b1, fixflo_pkg::REG_CTRL, 16'd1, rd);
      @(posedge clk);
      bus_access(1'b0, fixflo_pkg::REG_STATUS, '0, rd);
      bus_access(1'b0, fixflo_pkg::REG_RESULT, '0, rd);
      bus_access(1'b0, fixflo_pkg::REG_STATUS, '0, rd);   // done now clear
      report(6, "done handshake");
    end

    $display("summary: %0d checks, %0d errors, %0d timeouts",
             check_count, error_count, timeouts);
    if (error_count == 0 && timeouts == 0 && check_count > 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/tb_clock.sv
//======================================================================
// testbench clock and reset
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic reset
);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;   // 20 ns period
  end

  initial
  begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

`default_nettype wire
